/* filelist.f */
hdl/ecc_code_pkg.sv
hdl/ecc_io_pkg.sv
hdl/ecc_ingress.sv
hdl/ecc_encoder.sv
hdl/ecc_decoder.sv
hdl/ecc_egress.sv
hdl/ecc_codec_top.sv
verification/ecc_codec_checker.sv
verification/ecc_codec_monitor.sv
verification/ecc_codec_tb.sv

/* verification/ecc_codec_tb.sv */
/*
  testbench top for the SEC-DED codec
  clock, reset and falling-edge stimulus
  reference encode and decode from the hamming position rule
  drain waits with timeout and the closing summary
*/

`timescale 1ns/1ps

module ecc_codec_tb;

  logic                            clk;
  logic                            rst_n;
  logic                            enc_valid;
  logic [ecc_code_pkg::data_w-1:0] enc_data;
  logic                            dec_valid;
  ecc_io_pkg::codeword_t           dec_cw;
  logic                            enc_out_valid;
  ecc_io_pkg::codeword_t           enc_cw;
  logic                            dec_out_valid;
  ecc_io_pkg::dec_result_t         dec_res;
  logic [ecc_code_pkg::cnt_w-1:0]  corr_count;
  logic [ecc_code_pkg::cnt_w-1:0]  uncorr_count;

  ecc_io_pkg::codeword_t           enc_exp;    // predictions, travel with the strobe
  ecc_io_pkg::dec_result_t         dec_exp;
  logic [95:0]                     enc_name;   // test names as packed text
  logic [95:0]                     dec_name;
  int                              pending;
  int                              pass_cnt;
  int                              fail_cnt;
  int                              sent;       // items driven
  bit                              timed_out;
  integer                          seed;

  always #20 clk = ~clk;   // 40 ns period

  ecc_codec_top ecc_codec_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .enc_valid     (enc_valid),
    .enc_data      (enc_data),
    .dec_valid     (dec_valid),
    .dec_cw        (dec_cw),
    .enc_out_valid (enc_out_valid),
    .enc_cw        (enc_cw),
    .dec_out_valid (dec_out_valid),
    .dec_res       (dec_res),
    .corr_count    (corr_count),
    .uncorr_count  (uncorr_count)
  );

  ecc_codec_monitor monitor_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .enc_valid     (enc_valid),
    .enc_exp       (enc_exp),
    .enc_name      (enc_name),
    .dec_valid     (dec_valid),
    .dec_exp       (dec_exp),
    .dec_name      (dec_name),
    .enc_out_valid (enc_out_valid),
    .enc_cw        (enc_cw),
    .dec_out_valid (dec_out_valid),
    .dec_res       (dec_res),
    .corr_count    (corr_count),
    .uncorr_count  (uncorr_count),
    .pending       (pending),
    .pass_cnt      (pass_cnt),
    .fail_cnt      (fail_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // 1-based position of data bit j, powers of two skipped
  function automatic int data_pos(input int j);
    int pos;
    int n;
    pos = 0;
    n   = -1;
    while (n < j)
    begin
      pos++;
      if ((pos & (pos - 1)) != 0)
        n++;
    end
    return pos;
  endfunction

  function automatic ecc_io_pkg::codeword_t ref_encode(input logic [31:0] d);
    ecc_io_pkg::codeword_t cw;
    int acc;
    acc = 0;
    for (int j = 0; j < 32; j++)
      if (d[j])
        acc = acc ^ data_pos(j);   // check bits are the xor of set positions
    cw.data = d;
    cw.chk  = acc[5:0];
    cw.par  = ^{cw.chk, cw.data};
    return cw;
  endfunction

  function automatic ecc_io_pkg::dec_result_t ref_decode(input ecc_io_pkg::codeword_t cw);
    ecc_io_pkg::dec_result_t r;
    int s;
    s = 0;
    for (int k = 0; k < 6; k++)
      if (cw.chk[k])
        s = s ^ (1 << k);          // check bit k sits at position 2^k
    for (int j = 0; j < 32; j++)
      if (cw.data[j])
        s = s ^ data_pos(j);
    r.data     = cw.data;
    r.syndrome = s[5:0];
    if (^cw)
    begin
      r.cls = ecc_io_pkg::cls_corrected;
      for (int j = 0; j < 32; j++)
        if (data_pos(j) == s)
          r.data[j] = ~r.data[j];
    end
    else if (s != 0)
      r.cls = ecc_io_pkg::cls_uncorrectable;
    else
      r.cls = ecc_io_pkg::cls_clean;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // drive helpers
  //////////////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(negedge clk);
    enc_valid = 1'b0;
    dec_valid = 1'b0;
  endtask

  task automatic set_enc(input logic [31:0] d, input logic [95:0] nm);
    enc_valid = 1'b1;
    enc_data  = d;
    enc_exp   = ref_encode(d);
    enc_name  = nm;
    sent++;
  endtask

  task automatic set_dec(input ecc_io_pkg::codeword_t cw, input logic [95:0] nm);
    dec_valid = 1'b1;
    dec_cw    = cw;
    dec_exp   = ref_decode(cw);
    dec_name  = nm;
    sent++;
  endtask

  // wait until every item has left the DUT
  task automatic drain(input logic [95:0] nm);
    int n;
    n = 0;
    while (pending != 0 && n < 50)
    begin
      @(posedge clk);
      n++;
    end
    if (pending != 0)
    begin
      $display("timeout: %0d %0s items never got an output strobe", pending, nm);
      timed_out = 1'b1;
    end
  endtask

  initial
  begin
    ecc_io_pkg::codeword_t cw;
    int a;
    int b;
    seed      = 34;
    clk       = 1'b0;
    rst_n     = 1'b0;
    enc_valid = 1'b0;
    enc_data  = '0;
    dec_valid = 1'b0;
    dec_cw    = '0;
    enc_exp   = '0;
    dec_exp   = '0;
    enc_name  = '0;
    dec_name  = '0;
    sent      = 0;
    timed_out = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    next_cycle();

    // corner words then random, all back to back
    set_enc('0, "enc_zero");
    next_cycle();
    set_enc('1, "enc_ones");
    next_cycle();
    for (int i = 0; i < 32; i++)
    begin
      set_enc(32'h1 << i, "enc_walk");
      next_cycle();
    end
    for (int i = 0; i < 24; i++)
    begin
      set_enc($random(seed), "enc_rand");
      next_cycle();
    end
    drain("encode");

    for (int i = 0; i < 8; i++)
    begin
      set_dec(ref_encode($random(seed)), "dec_clean");
      next_cycle();
    end
    drain("clean");

    // every position once, encode channel busy alongside
    for (int i = 0; i < 39; i++)
    begin
      cw    = ref_encode($random(seed));
      cw[i] = ~cw[i];
      set_dec(cw, "dec_single");
      set_enc($random(seed), "enc_dual");
      next_cycle();
    end
    drain("single");

    for (int i = 0; i < 16; i++)
    begin
      cw    = ref_encode($random(seed));
      a     = $unsigned($random(seed)) % 39;
      b     = (a + 1 + $unsigned($random(seed)) % 38) % 39;   // never equal to a
      cw[a] = ~cw[a];
      cw[b] = ~cw[b];
      set_dec(cw, "dec_double");
      next_cycle();
    end
    drain("double");

    $display("tests: %0d passed, %0d failed of %0d, %0d assertion failures",
             pass_cnt, fail_cnt, sent + 1,
             ecc_codec_top_i.ecc_egress_i.ecc_codec_checker_i.assert_fails);
    if (fail_cnt == 0 && !timed_out && pass_cnt == sent + 1 &&
        ecc_codec_top_i.ecc_egress_i.ecc_codec_checker_i.assert_fails == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* verification/ecc_codec_monitor.sv */
/*
  checking module for the SEC-DED codec
  queues predictions at the input strobes
  compares results, counters and latency at the output strobes
  one line per test, pass and fail counts out
*/

`timescale 1ns/1ps

module ecc_codec_monitor (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            enc_valid,
  input  ecc_io_pkg::codeword_t           enc_exp,
  input  logic [95:0]                     enc_name,
  input  logic                            dec_valid,
  input  ecc_io_pkg::dec_result_t         dec_exp,
  input  logic [95:0]                     dec_name,
  input  logic                            enc_out_valid,
  input  ecc_io_pkg::codeword_t           enc_cw,
  input  logic                            dec_out_valid,
  input  ecc_io_pkg::dec_result_t         dec_res,
  input  logic [ecc_code_pkg::cnt_w-1:0]  corr_count,
  input  logic [ecc_code_pkg::cnt_w-1:0]  uncorr_count,
  output int                              pending,
  output int                              pass_cnt,
  output int                              fail_cnt
);

  ecc_io_pkg::codeword_t          enc_q[$];    // in flight, encode
  logic [95:0]                    enc_nq[$];
  int                             enc_tq[$];   // input edge of each item
  ecc_io_pkg::dec_result_t        dec_q[$];    // in flight, decode
  logic [95:0]                    dec_nq[$];
  int                             dec_tq[$];
  ecc_io_pkg::dec_result_t        exp_res;
  logic [95:0]                    cur_name;
  logic [ecc_code_pkg::cnt_w-1:0] exp_corr;    // running predicted counts
  logic [ecc_code_pkg::cnt_w-1:0] exp_uncorr;
  int                             in_cnt;
  int                             out_cnt;
  int                             item;
  int                             cyc;         // rising edges seen
  bit                             reset_done;

  assign pending = in_cnt - out_cnt;

  initial
  begin
    in_cnt   = 0;
    out_cnt  = 0;
    item     = 0;
    cyc      = 0;
    pass_cnt = 0;
    fail_cnt = 0;
  end

  task automatic compare_item(input logic [95:0] nm, input logic [127:0] exp_v,
                              input logic [127:0] act_v);
    if (exp_v === act_v)
    begin
      pass_cnt++;
      $display("test %0s #%0d: ok", nm, item);
    end
    else
    begin
      fail_cnt++;
      $display("mismatch %0s #%0d: expected %h actual %h", nm, item, exp_v, act_v);
    end
    item++;
  endtask

  // an output seen mid-cycle is first sampled at the next rising edge
  task automatic check_latency(input logic [95:0] nm, input int in_edge);
    int lat;
    lat = cyc + 1 - in_edge;
    if (lat != 2)   // one ingress and one egress stage
    begin
      fail_cnt++;
      $display("mismatch %0s #%0d latency: expected 2 actual %0d", nm, item, lat);
    end
  endtask

  // inputs settle at the falling edge, so the rising edge is safe
  always @(posedge clk)
  begin
    cyc++;
    if (rst_n && enc_valid)
    begin
      enc_q.push_back(enc_exp);
      enc_nq.push_back(enc_name);
      enc_tq.push_back(cyc);
      in_cnt++;
    end
    if (rst_n && dec_valid)
    begin
      dec_q.push_back(dec_exp);
      dec_nq.push_back(dec_name);
      dec_tq.push_back(cyc);
      in_cnt++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output side, sampled mid-cycle
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      reset_done = 1'b0;
      exp_corr   = '0;
      exp_uncorr = '0;
    end
    else
    begin
      if (!reset_done)
      begin
        compare_item("reset", '0, {enc_out_valid, dec_out_valid, corr_count, uncorr_count});
        reset_done = 1'b1;
      end
      if (enc_out_valid)
      begin
        if (enc_q.size() == 0)
        begin
          $display("enc_out_valid went high with no encode in flight");
          fail_cnt++;
        end
        else
        begin
          cur_name = enc_nq.pop_front();
          check_latency(cur_name, enc_tq.pop_front());
          compare_item(cur_name, enc_q.pop_front(), enc_cw);
          out_cnt++;
        end
      end
      if (dec_out_valid)
      begin
        if (dec_q.size() == 0)
        begin
          $display("dec_out_valid went high with no decode in flight");
          fail_cnt++;
        end
        else
        begin
          exp_res  = dec_q.pop_front();
          cur_name = dec_nq.pop_front();
          check_latency(cur_name, dec_tq.pop_front());
          if (exp_res.cls == ecc_io_pkg::cls_corrected && exp_corr != '1)
            exp_corr = exp_corr + 1'b1;
          if (exp_res.cls == ecc_io_pkg::cls_uncorrectable && exp_uncorr != '1)
            exp_uncorr = exp_uncorr + 1'b1;
          // result and both counters in one compare
          compare_item(cur_name, {exp_res, exp_corr, exp_uncorr},
                       {dec_res, corr_count, uncorr_count});
          out_cnt++;
        end
      end
    end
  end

endmodule

/* verification/ecc_codec_checker.sv */
/*
  bound assertions on the codec output stage
  counters never fall, move only with a matching decode
  output strobes known after reset
*/

`timescale 1ns/1ps

module ecc_codec_checker (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            enc_out_valid,
  input logic                            dec_out_valid,
  input ecc_io_pkg::ecc_class_t          dec_cls,
  input logic [ecc_code_pkg::cnt_w-1:0]  corr_count,
  input logic [ecc_code_pkg::cnt_w-1:0]  uncorr_count
);

  int assert_fails = 0;   // read by the testbench top

  corr_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
    corr_count >= $past(corr_count))
    else begin $error("corr_count decreased"); assert_fails++; end

  uncorr_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
    uncorr_count >= $past(uncorr_count))
    else begin $error("uncorr_count decreased"); assert_fails++; end

  // counter and result register load on the same edge
  corr_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(corr_count) |-> dec_out_valid && dec_cls == ecc_io_pkg::cls_corrected)
    else begin $error("corr_count moved without a corrected decode"); assert_fails++; end

  uncorr_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(uncorr_count) |-> dec_out_valid && dec_cls == ecc_io_pkg::cls_uncorrectable)
    else begin $error("uncorr_count moved without an uncorrectable decode"); assert_fails++; end

  strobes_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({enc_out_valid, dec_out_valid}))
    else begin $error("output strobe unknown"); assert_fails++; end

endmodule

bind ecc_egress ecc_codec_checker ecc_codec_checker_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .enc_out_valid (enc_out_valid),
  .dec_out_valid (dec_out_valid),
  .dec_cls       (dec_res_q.cls),
  .corr_count    (corr_count),
  .uncorr_count  (uncorr_count)
);

/* hdl/ecc_codec_top.sv */
/*
  ecc_codec_top
  two-cycle registered SEC-DED codec
  ingress regs, encoder and decoder, egress regs with counters
*/

`timescale 1ns/1ps

module ecc_codec_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            enc_valid,
  input  logic [ecc_code_pkg::data_w-1:0] enc_data,
  input  logic                            dec_valid,
  input  ecc_io_pkg::codeword_t           dec_cw,
  output logic                            enc_out_valid,
  output ecc_io_pkg::codeword_t           enc_cw,
  output logic                            dec_out_valid,
  output ecc_io_pkg::dec_result_t         dec_res,
  output logic [ecc_code_pkg::cnt_w-1:0]  corr_count,
  output logic [ecc_code_pkg::cnt_w-1:0]  uncorr_count
);

  logic                            enc_valid_q;   // stage 1 strobes
  logic                            dec_valid_q;
  logic [ecc_code_pkg::data_w-1:0] enc_data_q;    // stage 1 payloads
  ecc_io_pkg::codeword_t           dec_cw_q;
  ecc_io_pkg::codeword_t           enc_cw_c;      // combinational results
  ecc_io_pkg::dec_result_t         dec_res_c;

  ecc_ingress ecc_ingress_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .enc_valid   (enc_valid),
    .enc_data    (enc_data),
    .dec_valid   (dec_valid),
    .dec_cw      (dec_cw),
    .enc_valid_q (enc_valid_q),
    .enc_data_q  (enc_data_q),
    .dec_valid_q (dec_valid_q),
    .dec_cw_q    (dec_cw_q)
  );

  ecc_encoder ecc_encoder_i (
    .data (enc_data_q),
    .cw   (enc_cw_c)
  );

  ecc_decoder ecc_decoder_i (
    .cw  (dec_cw_q),
    .res (dec_res_c)
  );

  ecc_egress ecc_egress_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .enc_valid     (enc_valid_q),
    .enc_cw        (enc_cw_c),
    .dec_valid     (dec_valid_q),
    .dec_res       (dec_res_c),
    .enc_out_valid (enc_out_valid),
    .enc_cw_q      (enc_cw),
    .dec_out_valid (dec_out_valid),
    .dec_res_q     (dec_res),
    .corr_count    (corr_count),
    .uncorr_count  (uncorr_count)
  );

endmodule

/* hdl/ecc_egress.sv */
/*
  ecc_egress
  output register stage for encoder and decoder results
  saturating counters of corrected and uncorrectable words
*/

`timescale 1ns/1ps

module ecc_egress (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            enc_valid,
  input  ecc_io_pkg::codeword_t           enc_cw,
  input  logic                            dec_valid,
  input  ecc_io_pkg::dec_result_t         dec_res,
  output logic                            enc_out_valid,
  output ecc_io_pkg::codeword_t           enc_cw_q,
  output logic                            dec_out_valid,
  output ecc_io_pkg::dec_result_t         dec_res_q,
  output logic [ecc_code_pkg::cnt_w-1:0]  corr_count,
  output logic [ecc_code_pkg::cnt_w-1:0]  uncorr_count
);

  logic corr_hit;     // valid decode, corrected
  logic uncorr_hit;   // valid decode, uncorrectable

  assign corr_hit   = dec_valid && (dec_res.cls == ecc_io_pkg::cls_corrected);
  assign uncorr_hit = dec_valid && (dec_res.cls == ecc_io_pkg::cls_uncorrectable);

  //////////////////////////////////////////////////////////////////////
  // result registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      enc_out_valid <= 1'b0;
      dec_out_valid <= 1'b0;
      enc_cw_q      <= '0;
      dec_res_q     <= '0;
    end
    else
    begin
      enc_out_valid <= enc_valid;
      dec_out_valid <= dec_valid;
      enc_cw_q      <= enc_cw;    // follows upstream every cycle
      dec_res_q     <= dec_res;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // event counters, stick at all ones
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      corr_count   <= '0;
      uncorr_count <= '0;
    end
    else
    begin
      if (corr_hit && corr_count != '1)
        corr_count <= corr_count + 1'b1;
      if (uncorr_hit && uncorr_count != '1)
        uncorr_count <= uncorr_count + 1'b1;
    end
  end

endmodule

/* hdl/ecc_decoder.sv */
/*
  ecc_decoder
  combinational SEC-DED checker and corrector
  syndrome from recomputed check bits, overall parity check
  syndrome lookup into a one-hot flip of the data bit
  clean / corrected / uncorrectable classification
*/

`timescale 1ns/1ps

module ecc_decoder (
  input  ecc_io_pkg::codeword_t  cw,
  output ecc_io_pkg::dec_result_t res
);

  logic [ecc_code_pkg::chk_w-1:0]  chk_calc;  // check bits from received data
  logic [ecc_code_pkg::chk_w-1:0]  syn;       // received xor recomputed
  logic                            p_err;     // xor of all received bits
  logic [ecc_code_pkg::chk_w-1:0]  hit_idx;   // lookup result
  logic [ecc_code_pkg::data_w-1:0] flip;      // one-hot, or zero
  ecc_io_pkg::ecc_class_t          cls;

  //////////////////////////////////////////////////////////////////////
  // syndrome and overall check
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int k = 0; k < ecc_code_pkg::chk_w; k++)
    begin
      chk_calc[k] = ^(cw.data & ecc_code_pkg::chk_mask[k]);
    end
  end

  assign syn   = cw.chk ^ chk_calc;
  assign p_err = ^cw;   // odd count of flipped bits

  //////////////////////////////////////////////////////////////////////
  // classification
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (p_err)
      cls = ecc_io_pkg::cls_corrected;        // single bit, any position
    else if (syn != '0)
      cls = ecc_io_pkg::cls_uncorrectable;    // even count, nonzero syndrome
    else
      cls = ecc_io_pkg::cls_clean;
  end

  //////////////////////////////////////////////////////////////////////
  // correction
  //////////////////////////////////////////////////////////////////////
  assign hit_idx = ecc_code_pkg::syn_to_bit[syn];

  always_comb
  begin
    flip = '0;
    // check-bit and parity-bit hits leave the data alone
    if (cls == ecc_io_pkg::cls_corrected && !hit_idx[ecc_code_pkg::chk_w-1])
      flip[hit_idx[ecc_code_pkg::chk_w-2:0]] = 1'b1;
  end

  // uncorrectable words pass through since flip stays zero
  assign res.data     = cw.data ^ flip;
  assign res.syndrome = syn;
  assign res.cls      = cls;

endmodule

/* hdl/ecc_encoder.sv */
/*
  ecc_encoder
  combinational SEC-DED encoder for one 32-bit word
  six hamming check bits from the coverage masks
  overall parity over data and check bits
*/

`timescale 1ns/1ps

module ecc_encoder (
  input  logic [ecc_code_pkg::data_w-1:0]  data,
  output ecc_io_pkg::codeword_t            cw
);

  logic [ecc_code_pkg::chk_w-1:0] chk;   // p1 .. p32
  logic                           par;   // overall parity

  //////////////////////////////////////////////////////////////////////
  // check bits
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int k = 0; k < ecc_code_pkg::chk_w; k++)
    begin
      chk[k] = ^(data & ecc_code_pkg::chk_mask[k]);  // even parity per group
    end
  end

  // makes the xor of all 39 bits zero
  assign par = ^{chk, data};

  //////////////////////////////////////////////////////////////////////
  // pack
  //////////////////////////////////////////////////////////////////////
  assign cw.par  = par;
  assign cw.chk  = chk;
  assign cw.data = data;   // data passes through unchanged

endmodule

/* hdl/ecc_ingress.sv */
/*
  ecc_ingress
  input register stage for encode and decode channels
  strobes registered with reset, payloads loaded on strobe
*/

`timescale 1ns/1ps

module ecc_ingress (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             enc_valid,
  input  logic [ecc_code_pkg::data_w-1:0]  enc_data,
  input  logic                             dec_valid,
  input  ecc_io_pkg::codeword_t            dec_cw,
  output logic                             enc_valid_q,
  output logic [ecc_code_pkg::data_w-1:0]  enc_data_q,
  output logic                             dec_valid_q,
  output ecc_io_pkg::codeword_t            dec_cw_q
);

  // strobes, one cycle each
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      enc_valid_q <= 1'b0;
      dec_valid_q <= 1'b0;
    end
    else
    begin
      enc_valid_q <= enc_valid;
      dec_valid_q <= dec_valid;
    end
  end

  // payloads hold between strobes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      enc_data_q <= '0;
      dec_cw_q   <= '0;
    end
    else
    begin
      if (enc_valid)
        enc_data_q <= enc_data;   // encode word
      if (dec_valid)
        dec_cw_q   <= dec_cw;     // received codeword
    end
  end

endmodule

/* hdl/ecc_io_pkg.sv */
/*
  port bundles for the SEC-DED codec
  codeword_t     39-bit codeword, parity / check / data
  ecc_class_t    decode status class
  dec_result_t   corrected data, syndrome and class
*/

package ecc_io_pkg;

  //////////////////////////////////////////////////////////////////////
  // codeword
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                             par;   // bit 38, overall parity
    logic [ecc_code_pkg::chk_w-1:0]   chk;   // bits 37..32
    logic [ecc_code_pkg::data_w-1:0]  data;  // bits 31..0
  } codeword_t;

  //////////////////////////////////////////////////////////////////////
  // decode status
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    cls_clean         = 2'd0,  // s zero, p zero
    cls_corrected     = 2'd1,  // single error, p one
    cls_uncorrectable = 2'd2   // double error, s nonzero with p zero
  } ecc_class_t;

  // decoder result
  typedef struct packed {
    logic [ecc_code_pkg::data_w-1:0]  data;      // corrected or passed through
    logic [ecc_code_pkg::chk_w-1:0]   syndrome;  // raw hamming syndrome
    ecc_class_t                       cls;
  } dec_result_t;

endpackage

/* hdl/ecc_code_pkg.sv */
/*
  code geometry for the 39-bit extended hamming SEC-DED code
  data, check and codeword widths plus event counter width
  check-bit coverage masks over the 32 data bits
  syndrome to data bit lookup table
*/

package ecc_code_pkg;

  localparam int data_w = 32;                  // data word
  localparam int chk_w  = 6;                   // hamming check bits
  localparam int cw_w   = data_w + chk_w + 1;  // plus overall parity
  localparam int cnt_w  = 16;                  // event counters

  //////////////////////////////////////////////////////////////////////
  // position layout
  // check bits sit at 1 2 4 8 16 32, data fills 3..38 in order
  // mask k picks data bits whose position has bit k set
  //////////////////////////////////////////////////////////////////////
  localparam logic [data_w-1:0] chk_mask [chk_w] = '{
    32'h56AA_AD5B,  // p1
    32'h9B33_366D,  // p2
    32'hE3C3_C78E,  // p4
    32'h03FC_07F0,  // p8
    32'h03FF_F800,  // p16
    32'hFC00_0000   // p32
  };

  // bit 5 set means the syndrome names no data bit
  localparam logic [chk_w-1:0] no_bit = 6'h20;

  // indexed by syndrome
  localparam logic [chk_w-1:0] syn_to_bit [2**chk_w] = '{
    no_bit, no_bit, no_bit, 0,      no_bit, 1,      2,      3,       // 0..7
    no_bit, 4,      5,      6,      7,      8,      9,      10,      // 8..15
    no_bit, 11,     12,     13,     14,     15,     16,     17,      // 16..23
    18,     19,     20,     21,     22,     23,     24,     25,      // 24..31
    no_bit, 26,     27,     28,     29,     30,     31,     no_bit,  // 32..39
    no_bit, no_bit, no_bit, no_bit, no_bit, no_bit, no_bit, no_bit,  // beyond cw
    no_bit, no_bit, no_bit, no_bit, no_bit, no_bit, no_bit, no_bit,
    no_bit, no_bit, no_bit, no_bit, no_bit, no_bit, no_bit, no_bit
  };

endpackage
